// File: hw/mips_exec_pkg.sv
// widths, shamt field position, ALU/branch/flow encodings and the execute stage structs
package mips_exec_pkg;

   // datapath and register numbering
   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   // jal/jalr/bltzal style transfers write here
   localparam int link_reg   = 31;

   // shift amount sits in imm[10:6], as in the R-type encoding
   localparam int shamt_lsb  = 6;
   localparam int shamt_w    = 5;

   // j/jal target field, word addressed
   localparam int target_w   = 26;
   localparam int inst_bytes = 4;

   // integer ALU operations
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_nor  = 4'd5,
      alu_slt  = 4'd6,
      alu_sltu = 4'd7,
      alu_sll  = 4'd8,
      alu_srl  = 4'd9,
      alu_sra  = 4'd10,
      alu_sllv = 4'd11,
      alu_srlv = 4'd12,
      alu_srav = 4'd13
   } alu_op_e;

   // branch conditions; br_none never resolves taken
   typedef enum logic [2:0] {
      br_none = 3'd0,
      br_bltz = 3'd1,
      br_bgez = 3'd2,
      br_beq  = 3'd3,
      br_bne  = 3'd4,
      br_blez = 3'd5,
      br_bgtz = 3'd6
   } br_cond_e;

   // kind of control transfer
   typedef enum logic [1:0] {
      flow_none     = 2'd0,
      flow_branch   = 2'd1,
      flow_jump     = 2'd2,
      flow_jump_reg = 2'd3
   } flow_e;

   // decoded instruction as issued into execute
   typedef struct packed {
      logic                  valid;
      alu_op_e               alu_op;
      logic                  src_imm;
      logic                  shift_var;
      logic                  writes_reg;
      logic [reg_addr_w-1:0] dest;
      flow_e                 flow;
      br_cond_e              br_cond;
      logic                  link;
      logic [xlen-1:0]       pc;
      logic [xlen-1:0]       rs_val;
      logic [xlen-1:0]       rt_val;
      // already sign or zero extended by decode
      logic [xlen-1:0]       imm;
      logic [target_w-1:0]   target;
   } ex_op_t;

   // ALU pipeline register
   typedef struct packed {
      logic                  valid;
      logic                  writes_reg;
      logic [reg_addr_w-1:0] dest;
      logic [xlen-1:0]       result;
   } alu_stage_t;

   // branch pipeline register
   typedef struct packed {
      logic            taken;
      logic            link;
      logic [xlen-1:0] target_pc;
      logic [xlen-1:0] link_addr;
   } branch_stage_t;

   // register file write port
   typedef struct packed {
      logic                  valid;
      logic [reg_addr_w-1:0] dest;
      logic [xlen-1:0]       data;
   } wb_t;

   // next-pc override towards fetch
   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
   } redirect_t;

endpackage

// File: hw/exec_alu.sv
// operand select, integer ALU with shifter and its pipeline register
`timescale 1ns/1ps

module exec_alu (
   input  logic                      clk,
   input  logic                      rst_b,
   input  mips_exec_pkg::ex_op_t     op,
   output mips_exec_pkg::alu_stage_t alu_q
);

   import mips_exec_pkg::*;

   logic [xlen-1:0]    opa;
   logic [xlen-1:0]    opb;
   logic [xlen-1:0]    sh_src;
   logic [shamt_w-1:0] sh_amt;
   logic [xlen-1:0]    result;

   // control bits of the stage register
   logic                  valid_q;
   logic                  writes_q;
   // payload of the stage register
   logic [reg_addr_w-1:0] dest_q;
   logic [xlen-1:0]       result_q;

   // rs is always the first operand
   assign opa = op.rs_val;
   // second operand is the immediate for I-type forms
   assign opb = op.src_imm ? op.imm : op.rt_val;

   // immediate shifts move rs by imm[10:6]
   // variable shifts move rt by rs[4:0]
   assign sh_src = op.shift_var ? op.rt_val : op.rs_val;
   assign sh_amt = op.shift_var ? op.rs_val[shamt_w-1:0]
                                : op.imm[shamt_lsb +: shamt_w];

   always_comb begin
      result = '0;
      case (op.alu_op)
         alu_add:  result = opa + opb;
         alu_sub:  result = opa - opb;
         alu_and:  result = opa & opb;
         alu_or:   result = opa | opb;
         alu_xor:  result = opa ^ opb;
         alu_nor:  result = ~(opa | opb);
         // set-less-than gives 1 or 0
         alu_slt:  result = ($signed(opa) < $signed(opb)) ? xlen'(1) : '0;
         alu_sltu: result = (opa < opb) ? xlen'(1) : '0;
         // the v forms share the shifter and shift_var picks the operands
         alu_sll,
         alu_sllv: result = sh_src << sh_amt;
         alu_srl,
         alu_srlv: result = sh_src >> sh_amt;
         // arithmetic right keeps the sign bit
         alu_sra,
         alu_srav: result = $signed(sh_src) >>> sh_amt;
         default:  result = '0;
      endcase
   end

   // control bits of the stage
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         valid_q  <= 1'b0;
         writes_q <= 1'b0;
      end else begin
         valid_q  <= op.valid;
         writes_q <= op.valid & op.writes_reg;
      end
   end

   // destination and result of the issued item
   always_ff @(posedge clk) begin
      dest_q   <= op.dest;
      result_q <= result;
   end

   assign alu_q = '{
      valid:      valid_q,
      writes_reg: writes_q,
      dest:       dest_q,
      result:     result_q
   };

endmodule

// File: hw/branch_resolve.sv
// branch condition check, transfer target and link address, with stage register
`timescale 1ns/1ps

module branch_resolve (
   input  logic                         clk,
   input  logic                         rst_b,
   input  mips_exec_pkg::ex_op_t        op,
   output mips_exec_pkg::branch_stage_t br_q
);

   import mips_exec_pkg::*;

   logic            rs_neg;
   logic            rs_zero;
   logic            cond_ok;
   logic            taken;
   logic [xlen-1:0] pc_next;
   logic [xlen-1:0] br_target;
   logic [xlen-1:0] j_target;
   logic [xlen-1:0] target;

   logic            taken_q;
   logic            link_q;
   logic [xlen-1:0] target_q;
   logic [xlen-1:0] link_addr_q;

   // sign and zero tests of rs for the compare-with-zero forms
   assign rs_neg  = op.rs_val[xlen-1];
   assign rs_zero = (op.rs_val == '0);

   always_comb begin
      cond_ok = 1'b0;
      case (op.br_cond)
         br_bltz: cond_ok = rs_neg;
         br_bgez: cond_ok = !rs_neg;
         br_beq:  cond_ok = (op.rs_val == op.rt_val);
         br_bne:  cond_ok = (op.rs_val != op.rt_val);
         br_blez: cond_ok = rs_neg | rs_zero;
         br_bgtz: cond_ok = !rs_neg & !rs_zero;
         default: cond_ok = 1'b0;
      endcase
   end

   // jumps always go and branches only on their condition
   always_comb begin
      taken = 1'b0;
      case (op.flow)
         flow_branch:   taken = cond_ok;
         flow_jump:     taken = 1'b1;
         flow_jump_reg: taken = 1'b1;
         default:       taken = 1'b0;
      endcase
   end

   // pc+4 is both the branch base and the link value
   assign pc_next = op.pc + xlen'(inst_bytes);

   // word offset from the delay slot address
   assign br_target = pc_next + (op.imm << 2);

   // region bits of pc stay and the target fills the rest
   assign j_target = {op.pc[xlen-1 -: xlen-target_w-2], op.target, 2'b00};

   always_comb begin
      case (op.flow)
         flow_jump:     target = j_target;
         flow_jump_reg: target = op.rs_val;
         default:       target = br_target;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         taken_q <= 1'b0;
         link_q  <= 1'b0;
      end else begin
         taken_q <= op.valid & taken;
         link_q  <= op.valid & op.link;
      end
   end

   always_ff @(posedge clk) begin
      target_q    <= target;
      link_addr_q <= pc_next;
   end

   assign br_q = '{
      taken:     taken_q,
      link:      link_q,
      target_pc: target_q,
      link_addr: link_addr_q
   };

endmodule

// File: hw/exec_writeback.sv
// writeback and redirect merge of the two stage results, with the squash after a transfer
`timescale 1ns/1ps

module exec_writeback (
   input  logic                         clk,
   input  logic                         rst_b,
   input  mips_exec_pkg::alu_stage_t    alu_q,
   input  mips_exec_pkg::branch_stage_t br_q,
   output mips_exec_pkg::wb_t           wb,
   output mips_exec_pkg::redirect_t     redirect
);

   import mips_exec_pkg::*;

   // set for one cycle after a redirect leaves this stage
   logic      squash_q;
   logic      live;
   wb_t       wb_nxt;
   redirect_t redir_nxt;

   // the item right behind a taken transfer was fetched on the wrong path
   assign live = alu_q.valid & !squash_q;

   always_comb begin
      wb_nxt = '0;
      if (live) begin
         wb_nxt.valid = alu_q.writes_reg | br_q.link;
         // a linking transfer writes pc+4 to r31
         if (br_q.link) begin
            wb_nxt.dest = reg_addr_w'(link_reg);
            wb_nxt.data = br_q.link_addr;
         end else begin
            wb_nxt.dest = alu_q.dest;
            wb_nxt.data = alu_q.result;
         end
      end
   end

   always_comb begin
      redir_nxt = '0;
      if (live && br_q.taken) begin
         redir_nxt.valid = 1'b1;
         redir_nxt.pc    = br_q.target_pc;
      end
   end

   // bubbles and squashed items leave zeros on both ports
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb       <= '0;
         redirect <= '0;
         squash_q <= 1'b0;
      end else begin
         wb       <= wb_nxt;
         redirect <= redir_nxt;
         squash_q <= redir_nxt.valid;
      end
   end

endmodule

// File: hw/mips_execute_stage.sv
// top level with the ALU and branch resolver side by side feeding the writeback combiner
`timescale 1ns/1ps

module mips_execute_stage (
   input  logic                     clk,
   input  logic                     rst_b,
   input  mips_exec_pkg::ex_op_t    op,
   output mips_exec_pkg::wb_t       wb,
   output mips_exec_pkg::redirect_t redirect
);

   // first stage registers of both sides
   mips_exec_pkg::alu_stage_t    alu_q;
   mips_exec_pkg::branch_stage_t br_q;

   // integer result path
   exec_alu u_alu (
      .clk   (clk),
      .rst_b (rst_b),
      .op    (op),
      .alu_q (alu_q)
   );

   // control transfer path on the same issued item
   branch_resolve u_branch (
      .clk   (clk),
      .rst_b (rst_b),
      .op    (op),
      .br_q  (br_q)
   );

   // second stage that drives the ports two cycles after issue
   exec_writeback u_wb (
      .clk      (clk),
      .rst_b    (rst_b),
      .alu_q    (alu_q),
      .br_q     (br_q),
      .wb       (wb),
      .redirect (redirect)
   );

endmodule

// File: test/exec_model.svh
// reference functions for expected ALU results, branch outcomes, targets and link values
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// integer result as the ISA defines each operation
function automatic logic [xlen-1:0] alu_result(ex_op_t o);
   logic [xlen-1:0]   b;
   logic [4:0]        amt;
   logic [2*xlen-1:0] ext;
   b   = o.src_imm ? o.imm : o.rt_val;
   amt = o.shift_var ? o.rs_val[4:0] : o.imm[10:6];
   // arithmetic shift done as a logical shift of the sign-filled double word
   ext = o.shift_var ? {{xlen{o.rt_val[xlen-1]}}, o.rt_val} : {{xlen{o.rs_val[xlen-1]}}, o.rs_val};
   ext = ext >> amt;
   case (o.alu_op)
      alu_add:  return o.rs_val + b;
      alu_sub:  return o.rs_val + ~b + 1;
      alu_and:  return o.rs_val & b;
      alu_or:   return o.rs_val | b;
      alu_xor:  return o.rs_val ^ b;
      alu_nor:  return ~o.rs_val & ~b;
      // on differing signs the negative one is smaller
      alu_slt:  return (o.rs_val[31] != b[31]) ? o.rs_val[31] : (o.rs_val < b);
      alu_sltu: return (o.rs_val < b);
      alu_sll:  return o.rs_val << amt;
      alu_srl:  return o.rs_val >> amt;
      alu_sllv: return o.rt_val << amt;
      alu_srlv: return o.rt_val >> amt;
      default:  return ext[xlen-1:0];
   endcase
endfunction

// does the transfer happen
function automatic logic branch_taken(ex_op_t o);
   if (o.flow == flow_jump || o.flow == flow_jump_reg) return 1'b1;
   if (o.flow != flow_branch) return 1'b0;
   case (o.br_cond)
      br_bltz: return $signed(o.rs_val) < 0;
      br_bgez: return $signed(o.rs_val) >= 0;
      br_beq:  return o.rs_val == o.rt_val;
      br_bne:  return o.rs_val != o.rt_val;
      br_blez: return $signed(o.rs_val) <= 0;
      br_bgtz: return $signed(o.rs_val) > 0;
      default: return 1'b0;
   endcase
endfunction

// where a taken transfer goes
function automatic logic [xlen-1:0] transfer_target(ex_op_t o);
   if (o.flow == flow_jump) return {o.pc[31:28], o.target, 2'b00};
   if (o.flow == flow_jump_reg) return o.rs_val;
   return o.pc + 4 + o.imm * 4;
endfunction

// register write of a surviving item
function automatic wb_t expect_wb(ex_op_t o);
   wb_t w;
   w = '0;
   if (o.valid) begin
      w.valid = o.writes_reg | o.link;
      w.dest  = o.link ? 5'd31 : o.dest;
      w.data  = o.link ? o.pc + 4 : alu_result(o);
   end
   return w;
endfunction

// redirect of a surviving item
function automatic redirect_t expect_redirect(ex_op_t o);
   redirect_t r;
   r = '0;
   if (o.valid && branch_taken(o)) begin
      r.valid = 1'b1;
      r.pc    = transfer_target(o);
   end
   return r;
endfunction

`endif

// File: test/exec_tb.sv
// testbench clock, reset, random stimulus, expected-result queue, concurrent checks and report
`timescale 1ns/1ps

module exec_tb;

   import mips_exec_pkg::*;

   `include "exec_model.svh"

   // expected port values for one issued cycle
   typedef struct packed {
      logic      item;
      wb_t       wb;
      redirect_t redir;
   } expect_t;

   logic      clk;
   logic      rst_b;
   ex_op_t    op;
   wb_t       wb;
   redirect_t redirect;

   expect_t   exp_q[$];
   expect_t   head;
   wb_t       exp_wb;
   redirect_t exp_redir;
   logic      chk_on;
   // last issued cycle is expected to redirect
   logic      prev_redir;
   logic      timed_out;
   int        issued;
   int        checked;
   int        err_count;
   int        tests_run;
   int        tests_failed;
   int        test_errs;

   mips_execute_stage uut (
      .clk      (clk),
      .rst_b    (rst_b),
      .op       (op),
      .wb       (wb),
      .redirect (redirect)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // dest and data only matter when the write is valid
   wb_check: assert property (@(posedge clk) disable iff (!chk_on)
      (wb.valid == exp_wb.valid) &&
      (!wb.valid || ((wb.dest == exp_wb.dest) && (wb.data == exp_wb.data))))
   else begin
      err_count++;
      $display("Error at %0t: writeback %h, expected %h", $time, $sampled(wb), $sampled(exp_wb));
   end

   redirect_check: assert property (@(posedge clk) disable iff (!chk_on)
      (redirect.valid == exp_redir.valid) && (!redirect.valid || (redirect.pc == exp_redir.pc)))
   else begin
      err_count++;
      $display("Error at %0t: redirect %h, expected %h", $time,
               $sampled(redirect), $sampled(exp_redir));
   end

   // three entries queued means the head is the item now on the ports
   always @(negedge clk) begin
      if (exp_q.size() >= 3) begin
         head = exp_q.pop_front();
         exp_wb    <= head.wb;
         exp_redir <= head.redir;
         if (head.item) checked++;
      end else begin
         exp_wb    <= '0;
         exp_redir <= '0;
      end
   end

   // drive one cycle and queue what it should produce
   task automatic issue(input ex_op_t item);
      expect_t e;
      @(posedge clk);
      #2;
      op = item;
      e = '0;
      e.item = item.valid;
      // the follower of a taken transfer keeps an all-zero expectation
      if (!prev_redir) begin
         e.wb    = expect_wb(item);
         e.redir = expect_redirect(item);
      end
      prev_redir = e.redir.valid;
      exp_q.push_back(e);
      if (item.valid) issued++;
   endtask

   function automatic ex_op_t random_item();
      ex_op_t o;
      o = '0;
      o.valid      = 1'b1;
      o.alu_op     = alu_op_e'($urandom_range(7));
      o.writes_reg = 1'b1;
      o.dest       = reg_addr_w'($urandom_range(30, 1));
      o.pc         = $urandom() & 32'hffff_fffc;
      o.rs_val     = $urandom();
      o.rt_val     = $urandom();
      o.imm        = $urandom();
      o.target     = target_w'($urandom());
      return o;
   endfunction

   // bubbles until every valid item has been compared
   task automatic report_test(input string name);
      int n;
      n = 0;
      while ((checked != issued) && (n < 12)) begin
         issue('0);
         n++;
      end
      if (checked != issued) begin
         timed_out = 1'b1;
         $display("%s: gave up waiting, %0d results never checked", name, issued - checked);
      end
      tests_run++;
      if ((err_count != test_errs) || timed_out) begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, err_count - test_errs);
      end else begin
         $display("%s: ok", name);
      end
      test_errs = err_count;
   endtask

   task automatic check_latency();
      ex_op_t o;
      int     n;
      // ports stay quiet while only bubbles go in
      repeat (3) issue('0);
      o = random_item();
      issue(o);
      n = 0;
      while (!wb.valid && (n < 8)) begin
         issue('0);
         n++;
      end
      if (!wb.valid) begin
         timed_out = 1'b1;
         $display("latency: no writeback appeared after the first issue");
      end else begin
         latency_check: assert (n == 2)
         else begin
            err_count++;
            $display("Error at %0t: writeback after %0d cycles, expected 2", $time, n);
         end
      end
      report_test("latency");
   endtask

   task automatic alu_ops();
      ex_op_t o;
      for (int k = 0; k < 8; k++) begin
         for (int s = 0; s < 2; s++) begin
            o = random_item();
            o.alu_op  = alu_op_e'(k);
            o.src_imm = s[0];
            issue(o);
            // signs differ so slt and sltu disagree
            o.rs_val = 32'hffff_fff0;
            o.rt_val = 32'h0000_0005;
            o.imm    = 32'h0000_0005;
            issue(o);
         end
      end
      report_test("alu operations");
   endtask

   task automatic shift_ops();
      ex_op_t o;
      for (int k = 8; k < 14; k++) begin
         repeat (4) begin
            o = random_item();
            o.alu_op    = alu_op_e'(k);
            o.shift_var = (k >= 11);
            issue(o);
            // negative source for the arithmetic shifts
            o.rs_val[31] = 1'b1;
            o.rt_val[31] = 1'b1;
            issue(o);
         end
      end
      report_test("shifts");
   endtask

   task automatic branch_conds();
      ex_op_t      o;
      logic [31:0] r;
      for (int c = 1; c < 7; c++) begin
         for (int v = -1; v < 2; v++) begin
            for (int d = 0; d < 2; d++) begin
               o = random_item();
               o.writes_reg = 1'b0;
               o.flow       = flow_branch;
               o.br_cond    = br_cond_e'(c);
               // operands around zero that are equal or one apart
               o.rs_val     = v;
               o.rt_val     = v + d;
               r = $urandom();
               o.imm = {{16{r[15]}}, r[15:0]};
               issue(o);
               issue('0);
            end
         end
      end
      report_test("branches");
   endtask

   task automatic jump_forms();
      ex_op_t o;
      for (int k = 0; k < 8; k++) begin
         o = random_item();
         o.writes_reg = 1'b0;
         o.flow       = k[0] ? flow_jump_reg : flow_jump;
         o.link       = k[1];
         issue(o);
         issue('0);
      end
      report_test("jumps");
   endtask

   task automatic squash_follower();
      ex_op_t t;
      ex_op_t a;
      for (int k = 0; k < 4; k++) begin
         t = random_item();
         t.writes_reg = 1'b0;
         t.flow       = flow_jump;
         // odd rounds link so a dropped jump would also write r31
         t.link       = k[0];
         a = random_item();
         // dropped right behind the jump
         issue(t);
         issue(a);
         // kept when issued one cycle later
         issue(t);
         issue('0);
         issue(a);
         // a jump right behind another jump loses its redirect too
         issue(t);
         issue(t);
      end
      report_test("squash");
   endtask

   initial begin
      void'($urandom(29));
      rst_b        = 1'b0;
      op           = '0;
      exp_wb       = '0;
      exp_redir    = '0;
      chk_on       = 1'b0;
      prev_redir   = 1'b0;
      timed_out    = 1'b0;
      issued       = 0;
      checked      = 0;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_errs    = 0;
      repeat (5) @(posedge clk);
      #2;
      rst_b  = 1'b1;
      chk_on = 1'b1;
      check_latency();
      if (!timed_out) alu_ops();
      if (!timed_out) shift_ops();
      if (!timed_out) branch_conds();
      if (!timed_out) jump_forms();
      if (!timed_out) squash_follower();
      chk_on = 1'b0;
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
      if ((tests_failed == 0) && (err_count == 0) && !timed_out) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+test
hw/mips_exec_pkg.sv
hw/exec_alu.sv
hw/branch_resolve.sv
hw/exec_writeback.sv
hw/mips_execute_stage.sv
test/exec_tb.sv
